//--- rtl/aud_params.svh
`ifndef AUD_PARAMS_SVH
`define AUD_PARAMS_SVH

// audio word width, left channel only
`define AUD_SAMPLE_W 16

// sram word address width
`define AUD_ADDR_W 20

// fifo slots, also the starting credit count of each producer
`define AUD_FIFO_DEPTH 4

// bit clocks per lrck half period, counted from the lrck edge
`define AUD_FRAME_BITS 32

`endif

//--- rtl/aud_pkg.sv
`include "aud_params.svh"

package aud_pkg;

	// signed pcm word as stored in sram
	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// sram word address
	typedef logic [`AUD_ADDR_W-1:0] addr_t;

	// one write request, recorder to arbiter
	typedef struct packed {
		addr_t   addr;
		sample_t data;
	} sram_wr_t;

	// playback processing
	typedef enum logic [1:0] {
		FAST        = 2'd0,
		SLOW_HOLD   = 2'd1,
		SLOW_LINEAR = 2'd2
	} play_mode_e;

	// fast: step of speed+1, slow: factor 2**speed[1:0]
	typedef struct packed {
		play_mode_e mode;
		logic [2:0] speed;
	} play_cfg_t;

	// top level core state
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RECD = 2'd1,
		PLAY = 2'd2
	} core_state_e;

endpackage

//--- rtl/credit_fifo.sv
`include "aud_params.svh"

module credit_fifo #(
	parameter type T = logic [`AUD_SAMPLE_W-1:0],
	parameter int DEPTH = `AUD_FIFO_DEPTH
) (
	input  logic i_AUD_BCLK,
	input  logic i_rst_n,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_empty,
	output logic o_credit
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// a push into a full buffer is lost
	assign do_push = i_push && (count != CNT_W'(DEPTH));
	assign do_pop  = i_pop && !o_empty;
	assign o_empty = (count == '0);
	// head word visible before the pop
	assign o_data  = mem[rd_ptr];

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			o_credit <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per word taken
			o_credit <= do_pop;
		end
	end

	// storage
	always_ff @(posedge i_AUD_BCLK) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

endmodule

//--- rtl/aud_recorder.sv
`include "aud_params.svh"

module aud_recorder (
	input  logic              i_AUD_BCLK,
	input  logic              i_rst_n,
	input  logic              i_AUD_ADCLRCK,
	input  logic              i_AUD_ADCDAT,
	input  logic              i_en,
	input  logic              i_credit,
	output logic              o_push,
	output aud_pkg::sram_wr_t o_wr,
	output aud_pkg::addr_t    o_last_addr
);
	import aud_pkg::*;

	localparam int BIT_W  = $clog2(`AUD_SAMPLE_W + 1);
	localparam int CRED_W = $clog2(`AUD_FIFO_DEPTH + 1);

	logic lrck_d;
	logic en_d;
	logic lrck_fall;
	logic word_done;
	logic push_now;
	logic [BIT_W-1:0] bits_left;
	logic [CRED_W-1:0] credits;
	sample_t shift_q;
	sample_t word;
	addr_t addr_q;

	// left half starts on lrck falling
	assign lrck_fall = lrck_d && !i_AUD_ADCLRCK;
	// lsb arrives on this edge
	assign word_done = (bits_left == BIT_W'(1));
	assign word      = {shift_q[`AUD_SAMPLE_W-2:0], i_AUD_ADCDAT};
	// no credit means the word is dropped
	assign push_now  = word_done && i_en && (credits != '0);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d      <= 1'b0;
			en_d        <= 1'b0;
			bits_left   <= '0;
			credits     <= CRED_W'(`AUD_FIFO_DEPTH);
			addr_q      <= '0;
			o_last_addr <= '0;
			o_push      <= 1'b0;
		end else begin
			lrck_d <= i_AUD_ADCLRCK;
			en_d   <= i_en;
			o_push <= push_now;
			credits <= credits - CRED_W'(push_now) + CRED_W'(i_credit);
			// edge cycle is the skipped slot, msb follows
			if (lrck_fall && i_en)
				bits_left <= BIT_W'(`AUD_SAMPLE_W);
			else if (bits_left != '0)
				bits_left <= bits_left - 1'b1;
			// new take starts at address zero
			if (i_en && !en_d) begin
				addr_q <= '0;
			end else if (push_now) begin
				addr_q      <= addr_q + 1'b1;
				o_last_addr <= addr_q;
			end
		end
	end

	// shifter and request payload
	always_ff @(posedge i_AUD_BCLK) begin
		if (bits_left != '0)
			shift_q <= word;
		if (push_now) begin
			o_wr.addr <= addr_q;
			o_wr.data <= word;
		end
	end

endmodule

//--- rtl/aud_dsp.sv
`include "aud_params.svh"

module aud_dsp (
	input  logic               i_AUD_BCLK,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  aud_pkg::play_cfg_t i_cfg,
	input  aud_pkg::addr_t     i_last_addr,
	input  logic               i_rd_valid,
	input  aud_pkg::sample_t   i_rd_data,
	input  logic               i_credit,
	output logic               o_rd_req,
	output aud_pkg::addr_t     o_rd_addr,
	output logic               o_push,
	output aud_pkg::sample_t   o_sample,
	output logic               o_done
);
	import aud_pkg::*;

	localparam int CRED_W = $clog2(`AUD_FIFO_DEPTH + 1);
	localparam int AW     = `AUD_ADDR_W + 1;

	typedef enum logic [2:0] {
		S_IDLE, S_RD_CUR, S_WAIT_CUR, S_RD_NXT, S_WAIT_NXT, S_OUT, S_DONE
	} dsp_state_e;

	dsp_state_e state;
	play_cfg_t cfg_q;
	addr_t addr_q;
	logic [2:0] phase_q;
	logic [2:0] phase_max;
	logic [1:0] slow_k;
	logic [AW-1:0] fast_nxt;
	logic [CRED_W-1:0] credits;
	logic last_word;
	logic phase_end;
	sample_t cur_q;
	sample_t nxt_q;
	logic signed [`AUD_SAMPLE_W:0] diff;
	logic signed [`AUD_SAMPLE_W+4:0] prod;
	logic signed [`AUD_SAMPLE_W+4:0] scaled;

	// slow factor 2**k, phase runs 0..2**k-1
	assign slow_k    = cfg_q.speed[1:0];
	assign phase_max = 3'((4'd1 << slow_k) - 4'd1);
	assign phase_end = (phase_q == phase_max);
	// fast step is speed+1, one spare bit catches the overrun
	assign fast_nxt  = {1'b0, addr_q} + AW'(cfg_q.speed) + AW'(1);
	assign last_word = (addr_q == i_last_addr);

	// read port toward the arbiter
	assign o_rd_req  = (state == S_RD_CUR) || (state == S_RD_NXT);
	assign o_rd_addr = (state == S_RD_NXT) ? addr_q + 1'b1 : addr_q;
	assign o_push    = (state == S_OUT) && (credits != '0);
	assign o_done    = (state == S_DONE);

	// cur + ((nxt - cur) * j) >>> k
	always_comb begin
		diff   = {nxt_q[`AUD_SAMPLE_W-1], nxt_q} - {cur_q[`AUD_SAMPLE_W-1], cur_q};
		prod   = diff * $signed({1'b0, phase_q});
		scaled = prod >>> slow_k;
		if (cfg_q.mode == SLOW_LINEAR)
			o_sample = cur_q + sample_t'(scaled);
		else
			o_sample = cur_q;
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			state   <= S_IDLE;
			cfg_q   <= '0;
			addr_q  <= '0;
			phase_q <= '0;
			credits <= CRED_W'(`AUD_FIFO_DEPTH);
		end else begin
			credits <= credits - CRED_W'(o_push) + CRED_W'(i_credit);
			if (!i_en) begin
				state <= S_IDLE;
			end else begin
				case (state)
					S_IDLE: begin
						// settings held for the whole run
						cfg_q   <= i_cfg;
						addr_q  <= '0;
						phase_q <= '0;
						state   <= S_RD_CUR;
					end
					S_RD_CUR:
						state <= S_WAIT_CUR;
					S_WAIT_CUR:
						// last word interpolates against itself
						if (i_rd_valid)
							state <= (cfg_q.mode == SLOW_LINEAR && !last_word) ? S_RD_NXT : S_OUT;
					S_RD_NXT:
						state <= S_WAIT_NXT;
					S_WAIT_NXT:
						if (i_rd_valid)
							state <= S_OUT;
					S_OUT:
						// no credit, stall with address and phase held
						if (o_push) begin
							if (cfg_q.mode == FAST) begin
								if (fast_nxt > {1'b0, i_last_addr}) begin
									state <= S_DONE;
								end else begin
									addr_q <= addr_t'(fast_nxt);
									state  <= S_RD_CUR;
								end
							end else if (!phase_end) begin
								phase_q <= phase_q + 1'b1;
							end else begin
								phase_q <= '0;
								if (last_word) begin
									state <= S_DONE;
								end else begin
									addr_q <= addr_q + 1'b1;
									state  <= S_RD_CUR;
								end
							end
						end
					S_DONE:
						state <= S_DONE;
					default:
						state <= S_IDLE;
				endcase
			end
		end
	end

	// fetched words
	always_ff @(posedge i_AUD_BCLK) begin
		if (state == S_WAIT_CUR && i_rd_valid) begin
			cur_q <= i_rd_data;
			nxt_q <= i_rd_data;
		end
		if (state == S_WAIT_NXT && i_rd_valid)
			nxt_q <= i_rd_data;
	end

endmodule

//--- rtl/aud_player.sv
`include "aud_params.svh"

module aud_player (
	input  logic             i_AUD_BCLK,
	input  logic             i_rst_n,
	input  logic             i_AUD_DACLRCK,
	input  aud_pkg::sample_t i_data,
	input  logic             i_empty,
	output logic             o_pop,
	output logic             o_AUD_DACDAT
);
	import aud_pkg::*;

	localparam int BIT_W = $clog2(`AUD_SAMPLE_W + 1);

	logic lrck_d;
	logic lrck_fall;
	logic lrck_rise;
	logic [BIT_W-1:0] bits_left;
	sample_t fresh;
	sample_t word_q;
	sample_t shift_q;

	assign lrck_fall = lrck_d && !i_AUD_DACLRCK;
	assign lrck_rise = !lrck_d && i_AUD_DACLRCK;
	// one sample per frame, taken on the left edge
	assign o_pop     = lrck_fall && !i_empty;
	// underrun plays silence
	assign fresh     = i_empty ? '0 : i_data;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d       <= 1'b0;
			bits_left    <= '0;
			word_q       <= '0;
			o_AUD_DACDAT <= 1'b0;
		end else begin
			lrck_d <= i_AUD_DACLRCK;
			if (lrck_fall) begin
				word_q       <= fresh;
				bits_left    <= BIT_W'(`AUD_SAMPLE_W);
				o_AUD_DACDAT <= 1'b0;
			end else if (lrck_rise) begin
				// right half repeats the left word
				bits_left    <= BIT_W'(`AUD_SAMPLE_W);
				o_AUD_DACDAT <= 1'b0;
			end else if (bits_left != '0) begin
				o_AUD_DACDAT <= shift_q[`AUD_SAMPLE_W-1];
				bits_left    <= bits_left - 1'b1;
			end else begin
				// pad to the end of the half frame
				o_AUD_DACDAT <= 1'b0;
			end
		end
	end

	// msb first shifter
	always_ff @(posedge i_AUD_BCLK) begin
		if (lrck_fall)
			shift_q <= fresh;
		else if (lrck_rise)
			shift_q <= word_q;
		else if (bits_left != '0)
			shift_q <= shift_q << 1;
	end

endmodule

//--- rtl/sram_port_arbiter.sv
module sram_port_arbiter (
	input  logic                 i_AUD_BCLK,
	input  logic                 i_rst_n,
	input  logic                 i_start,
	input  logic                 i_stop,
	input  logic                 i_rec_play,
	input  aud_pkg::sram_wr_t    i_wr,
	input  logic                 i_wr_empty,
	input  logic                 i_rd_req,
	input  aud_pkg::addr_t       i_rd_addr,
	input  aud_pkg::sample_t     i_sram_rdata,
	input  logic                 i_play_done,
	output logic                 o_wr_pop,
	output logic                 o_rd_valid,
	output aud_pkg::sample_t     o_rd_data,
	output aud_pkg::addr_t       o_sram_addr,
	output logic                 o_sram_we_n,
	output aud_pkg::sample_t     o_sram_wdata,
	output logic                 o_rec_en,
	output logic                 o_play_en,
	output aud_pkg::core_state_e o_state
);
	import aud_pkg::*;

	core_state_e state_nxt;
	logic wrap;

	assign o_rec_en  = (o_state == RECD);
	assign o_play_en = (o_state == PLAY);

	// drain one word per cycle while recording
	assign o_wr_pop     = o_rec_en && !i_wr_empty;
	assign o_sram_we_n  = !o_wr_pop;
	assign o_sram_addr  = o_rec_en ? i_wr.addr : i_rd_addr;
	assign o_sram_wdata = i_wr.data;
	// sram answers one cycle after the address
	assign o_rd_data    = i_sram_rdata;
	// top address just written, memory full
	assign wrap         = o_wr_pop && (i_wr.addr == '1);

	always_comb begin
		state_nxt = o_state;
		case (o_state)
			IDLE:
				if (i_start)
					state_nxt = i_rec_play ? RECD : PLAY;
			RECD:
				if (i_stop || wrap)
					state_nxt = IDLE;
			PLAY:
				if (i_stop || i_play_done)
					state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			o_state    <= IDLE;
			o_rd_valid <= 1'b0;
		end else begin
			o_state    <= state_nxt;
			o_rd_valid <= i_rd_req && o_play_en;
		end
	end

endmodule

//--- rtl/aud_top.sv
`include "aud_params.svh"

module aud_top (
	input  logic                 i_AUD_BCLK,
	input  logic                 i_rst_n,
	input  logic                 i_start,
	input  logic                 i_stop,
	input  logic                 i_rec_play,
	input  aud_pkg::play_cfg_t   i_play_cfg,
	input  logic                 i_AUD_ADCLRCK,
	input  logic                 i_AUD_ADCDAT,
	input  logic                 i_AUD_DACLRCK,
	output logic                 o_AUD_DACDAT,
	output aud_pkg::addr_t       o_sram_addr,
	output logic                 o_sram_we_n,
	output aud_pkg::sample_t     o_sram_wdata,
	input  aud_pkg::sample_t     i_sram_rdata,
	output aud_pkg::core_state_e o_state
);
	import aud_pkg::*;

	// core enables
	logic rec_en;
	logic play_en;
	// record path
	logic wr_push;
	logic wr_pop;
	logic wr_empty;
	logic wr_credit;
	sram_wr_t wr_in;
	sram_wr_t wr_out;
	addr_t last_addr;
	// dsp reads
	logic rd_req;
	logic rd_valid;
	addr_t rd_addr;
	sample_t rd_data;
	// playback path
	logic play_push;
	logic play_pop;
	logic play_empty;
	logic play_credit;
	logic play_done;
	sample_t play_in;
	sample_t play_out;

	aud_recorder recorder_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_ADCLRCK (i_AUD_ADCLRCK),
		.i_AUD_ADCDAT  (i_AUD_ADCDAT),
		.i_en          (rec_en),
		.i_credit      (wr_credit),
		.o_push        (wr_push),
		.o_wr          (wr_in),
		.o_last_addr   (last_addr)
	);

	credit_fifo #(.T(sram_wr_t), .DEPTH(`AUD_FIFO_DEPTH)) wr_fifo_i (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_push     (wr_push),
		.i_data     (wr_in),
		.i_pop      (wr_pop),
		.o_data     (wr_out),
		.o_empty    (wr_empty),
		.o_credit   (wr_credit)
	);

	aud_dsp dsp_i (
		.i_AUD_BCLK  (i_AUD_BCLK),
		.i_rst_n     (i_rst_n),
		.i_en        (play_en),
		.i_cfg       (i_play_cfg),
		.i_last_addr (last_addr),
		.i_rd_valid  (rd_valid),
		.i_rd_data   (rd_data),
		.i_credit    (play_credit),
		.o_rd_req    (rd_req),
		.o_rd_addr   (rd_addr),
		.o_push      (play_push),
		.o_sample    (play_in),
		.o_done      (play_done)
	);

	credit_fifo #(.T(sample_t), .DEPTH(`AUD_FIFO_DEPTH)) play_fifo_i (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_push     (play_push),
		.i_data     (play_in),
		.i_pop      (play_pop),
		.o_data     (play_out),
		.o_empty    (play_empty),
		.o_credit   (play_credit)
	);

	aud_player player_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_DACLRCK (i_AUD_DACLRCK),
		.i_data        (play_out),
		.i_empty       (play_empty),
		.o_pop         (play_pop),
		.o_AUD_DACDAT  (o_AUD_DACDAT)
	);

	sram_port_arbiter arbiter_i (
		.i_AUD_BCLK   (i_AUD_BCLK),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_stop       (i_stop),
		.i_rec_play   (i_rec_play),
		.i_wr         (wr_out),
		.i_wr_empty   (wr_empty),
		.i_rd_req     (rd_req),
		.i_rd_addr    (rd_addr),
		.i_sram_rdata (i_sram_rdata),
		.i_play_done  (play_done),
		.o_wr_pop     (wr_pop),
		.o_rd_valid   (rd_valid),
		.o_rd_data    (rd_data),
		.o_sram_addr  (o_sram_addr),
		.o_sram_we_n  (o_sram_we_n),
		.o_sram_wdata (o_sram_wdata),
		.o_rec_en     (rec_en),
		.o_play_en    (play_en),
		.o_state      (o_state)
	);

endmodule

//--- verification/aud_top_chk.sv
`include "aud_params.svh"

module aud_top_chk (
	input logic                 i_AUD_BCLK,
	input logic                 i_rst_n,
	input aud_pkg::core_state_e i_state,
	input logic                 i_sram_we_n,
	input logic                 i_wr_push,
	input logic                 i_wr_pop,
	input logic                 i_play_push,
	input logic                 i_play_pop
);
	import aud_pkg::*;

	logic [3:0] wr_occ;
	logic [3:0] play_occ;

	// fifo fill levels seen from outside
	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			wr_occ   <= '0;
			play_occ <= '0;
		end else begin
			wr_occ   <= wr_occ + 4'(i_wr_push) - 4'(i_wr_pop);
			play_occ <= play_occ + 4'(i_play_push) - 4'(i_play_pop);
		end
	end

	// sram writes only while recording
	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_state != RECD |-> i_sram_we_n)
		else $error("sram write outside record state");

	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_wr_push |-> wr_occ < 4'(`AUD_FIFO_DEPTH))
		else $error("write fifo pushed while full");

	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_play_push |-> play_occ < 4'(`AUD_FIFO_DEPTH))
		else $error("playback fifo pushed while full");

	// every write drains a stored word
	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!i_sram_we_n |-> wr_occ != '0)
		else $error("sram write with write fifo empty");

endmodule

bind aud_top aud_top_chk chk_i (
	.i_AUD_BCLK  (i_AUD_BCLK),
	.i_rst_n     (i_rst_n),
	.i_state     (o_state),
	.i_sram_we_n (o_sram_we_n),
	.i_wr_push   (wr_push),
	.i_wr_pop    (wr_pop),
	.i_play_push (play_push),
	.i_play_pop  (play_pop)
);

//--- verification/aud_top_tb.sv
module aud_top_tb;
	import aud_pkg::*;

	localparam int STIM_WORDS = 128;
	localparam int SRAM_WORDS = 1024;
	localparam int WAIT_LIMIT = 500;

	logic i_AUD_BCLK;
	logic i_rst_n;
	logic i_start;
	logic i_stop;
	logic i_rec_play;
	play_cfg_t i_play_cfg;
	logic i_AUD_ADCLRCK;
	logic i_AUD_ADCDAT;
	logic i_AUD_DACLRCK;
	logic o_AUD_DACDAT;
	addr_t o_sram_addr;
	logic o_sram_we_n;
	sample_t o_sram_wdata;
	sample_t i_sram_rdata;
	core_state_e o_state;

	// flat word list from the stimulus file
	logic [15:0] stim [0:STIM_WORDS-1];
	// behavioral sram, low address bits only
	sample_t sram [0:SRAM_WORDS-1];
	sample_t rec [0:63];
	addr_t last_wr_addr;
	int wr_count;

	aud_top aud_top_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_start       (i_start),
		.i_stop        (i_stop),
		.i_rec_play    (i_rec_play),
		.i_play_cfg    (i_play_cfg),
		.i_AUD_ADCLRCK (i_AUD_ADCLRCK),
		.i_AUD_ADCDAT  (i_AUD_ADCDAT),
		.i_AUD_DACLRCK (i_AUD_DACLRCK),
		.o_AUD_DACDAT  (o_AUD_DACDAT),
		.o_sram_addr   (o_sram_addr),
		.o_sram_we_n   (o_sram_we_n),
		.o_sram_wdata  (o_sram_wdata),
		.i_sram_rdata  (i_sram_rdata),
		.o_state       (o_state)
	);

	initial begin
		i_AUD_BCLK = 1'b0;
		forever #50 i_AUD_BCLK = ~i_AUD_BCLK;
	end

	// sram model, read data one cycle after the address
	always @(posedge i_AUD_BCLK) begin
		if (!o_sram_we_n) begin
			sram[o_sram_addr[9:0]] <= o_sram_wdata;
			last_wr_addr <= o_sram_addr;
			wr_count <= wr_count + 1;
		end
		i_sram_rdata <= sram[o_sram_addr[9:0]];
	end

	task automatic abort_with(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp)
			abort_with($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			abort_with($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_state(input core_state_e got, input core_state_e exp, input string what);
		if (got !== exp)
			abort_with($sformatf("[FAIL] %0t %s: got %s, expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_with($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp));
	endtask

	// interpolation rule, plain integer math
	function automatic sample_t interp(input sample_t cur, input sample_t nxt, input int j,
		input int k);
		int d;
		d = (int'(nxt) - int'(cur)) * j;
		return sample_t'(int'(cur) + (d >>> k));
	endfunction

	task automatic wait_state(input core_state_e s, input string what);
		int n;
		n = 0;
		while (o_state !== s) begin
			if (n == WAIT_LIMIT)
				abort_with($sformatf("Timeout: o_state never reached %s (%s)", s.name(), what));
			@(posedge i_AUD_BCLK);
			#10;
			n++;
		end
	endtask

	// playback fifo holds a word before the first frame
	task automatic wait_fill();
		int n;
		n = 0;
		while (aud_top_i.play_empty !== 1'b0) begin
			if (n == WAIT_LIMIT)
				abort_with("Timeout: the DSP never filled the playback FIFO");
			@(posedge i_AUD_BCLK);
			#10;
			n++;
		end
	endtask

	task automatic start_core(input logic rec_mode, input play_cfg_t cfg);
		@(posedge i_AUD_BCLK);
		#10;
		i_rec_play = rec_mode;
		i_play_cfg = cfg;
		i_start = 1'b1;
		@(posedge i_AUD_BCLK);
		#10;
		i_start = 1'b0;
	endtask

	task automatic pulse_stop();
		@(posedge i_AUD_BCLK);
		#10;
		i_stop = 1'b1;
		@(posedge i_AUD_BCLK);
		#10;
		i_stop = 1'b0;
	endtask

	// one lrck frame, adc word in and both dac words out
	task automatic run_frame(input sample_t adc, output sample_t dac, output sample_t dac_r);
		dac = '0;
		dac_r = '0;
		for (int c = 0; c < 64; c++) begin
			@(posedge i_AUD_BCLK);
			#10;
			// msb is dac bit clock two after the edge slot
			if (c >= 2 && c <= 17)
				dac[17-c] = o_AUD_DACDAT;
			// same spacing after the rising edge
			if (c >= 34 && c <= 49)
				dac_r[49-c] = o_AUD_DACDAT;
			i_AUD_ADCLRCK = (c >= 32);
			i_AUD_DACLRCK = (c >= 32);
			// one skipped bit, then msb first
			i_AUD_ADCDAT = (c >= 1 && c <= 16) ? adc[16-c] : 1'b0;
		end
	endtask

	initial begin
		int sp;
		int n_samples;
		int n_runs;
		int n_out;
		int k;
		play_cfg_t cfg;
		sample_t dac;
		sample_t dac_r;

		i_rst_n = 1'b1;
		i_start = 1'b0;
		i_stop = 1'b0;
		i_rec_play = 1'b0;
		i_play_cfg = '0;
		i_AUD_ADCLRCK = 1'b1;
		i_AUD_DACLRCK = 1'b1;
		i_AUD_ADCDAT = 1'b0;
		i_sram_rdata = '0;
		wr_count = 0;
		last_wr_addr = '0;
		// unwritten words carry their own address
		for (int i = 0; i < SRAM_WORDS; i++)
			sram[i] = sample_t'(i) ^ sample_t'(16'hc35a);
		$readmemh("verification/aud_stim.txt", stim);

		repeat (5) @(posedge i_AUD_BCLK);
		#10;
		i_rst_n = 1'b0;
		check_state(o_state, IDLE, "state after reset");
		check_bit(o_AUD_DACDAT, 1'b0, "dac data after reset");

		// record the samples
		n_samples = int'(stim[0]);
		sp = 1;
		start_core(1'b1, '0);
		wait_state(RECD, "record start");
		for (int i = 0; i < n_samples; i++) begin
			rec[i] = sample_t'(stim[sp]);
			sp++;
			run_frame(rec[i], dac, dac_r);
		end
		pulse_stop();
		wait_state(IDLE, "record stop");
		for (int i = 0; i < n_samples; i++)
			check_sample(sram[i], rec[i], $sformatf("sram word %0d", i));
		check_addr(last_wr_addr, addr_t'(n_samples - 1), "last written address");
		check_addr(addr_t'(wr_count), addr_t'(n_samples), "number of sram writes");

		// playback runs from the file
		n_runs = int'(stim[sp]);
		sp++;
		for (int r = 0; r < n_runs; r++) begin
			cfg.mode = play_mode_e'(stim[sp][1:0]);
			cfg.speed = stim[sp+1][2:0];
			n_out = int'(stim[sp+2]);
			sp += 3;
			// file values must follow the interpolation rule
			if (cfg.mode == SLOW_LINEAR) begin
				k = int'(cfg.speed[1:0]);
				for (int o = 0; o < n_out; o++)
					check_sample(sample_t'(stim[sp+o]),
						interp(rec[o >> k], rec[((o >> k) + 1 < n_samples) ? (o >> k) + 1 : o >> k],
							o % (1 << k), k),
						$sformatf("linear reference word %0d", o));
			end
			start_core(1'b0, cfg);
			wait_state(PLAY, "playback start");
			wait_fill();
			for (int o = 0; o < n_out; o++) begin
				run_frame('0, dac, dac_r);
				check_sample(dac, sample_t'(stim[sp+o]), $sformatf("run %0d word %0d", r, o));
				check_sample(dac_r, sample_t'(stim[sp+o]),
					$sformatf("run %0d right word %0d", r, o));
			end
			sp += n_out;
			wait_state(IDLE, "playback end");
			run_frame('0, dac, dac_r);
			check_sample(dac, '0, $sformatf("silence after run %0d", r));
			check_sample(dac_r, '0, $sformatf("right silence after run %0d", r));
		end

		// stop in the middle of playback
		cfg.mode = FAST;
		cfg.speed = 3'd0;
		start_core(1'b0, cfg);
		wait_state(PLAY, "early stop start");
		wait_fill();
		run_frame('0, dac, dac_r);
		check_sample(dac, rec[0], "first word before stop");
		check_sample(dac_r, rec[0], "first right word before stop");
		// words are still pending, so the core must still be playing
		check_state(o_state, PLAY, "state before stop");
		pulse_stop();
		// stop takes effect on the edge that samples it
		check_state(o_state, IDLE, "state after stop");

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- verification/aud_stim.txt
// sample count, then the recorded samples in order
// run count, then per run: mode speed count expected-dac-words
0006
0100 0300 fe00 0040 1000 0a00
0004
0000 0000 0006 0100 0300 fe00 0040 1000 0a00
0000 0002 0002 0100 0040
0001 0002 0018
0100 0100 0100 0100 0300 0300 0300 0300 fe00 fe00 fe00 fe00
0040 0040 0040 0040 1000 1000 1000 1000 0a00 0a00 0a00 0a00
0002 0001 000c
0100 0200 0300 0080 fe00 ff20 0040 0820 1000 0d00 0a00 0a00

//--- flist.f
+incdir+rtl
rtl/aud_pkg.sv
rtl/credit_fifo.sv
rtl/aud_recorder.sv
rtl/aud_dsp.sv
rtl/aud_player.sv
rtl/sram_port_arbiter.sv
rtl/aud_top.sv
verification/aud_top_chk.sv
verification/aud_top_tb.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = aud_top_tb
FLIST = flist.f

BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | awk '{ print } /^Finished with no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
